// ==== Bender.yml ====
package:
  name: pr

sources:
  - common/pr_pkg.sv
  - verilog/regs.sv
  - r0/r0_ctl.sv
  - r0/r0.sv
  - verilog/nb_q_bs.sv
  - verilog/pr.sv
  - target: simulation
    files:
      - sim/pr_tb.sv

// ==== common/pr_pkg.sv ====
/*
	Shared types for the P-R register unit
	Word, flag, register address, NB and RS vectors plus R0 flag bit indices
*/

`default_nettype none

package pr_pkg;

	// Data word, bit 0 is the MSB as on the W and L buses
	typedef logic [0:15] word_t;

	// CPU flags held in R0 bits 0..8
	typedef logic [0:8] flags_t;

	// Register number, 0 is R0 and 1..7 are user registers
	typedef logic [2:0] reg_addr_t;

	// Memory block number (BAR)
	typedef logic [0:3] nb_t;

	// RS value routed to KI
	typedef logic [0:9] rs_t;

	// Flag positions inside flags_t
	localparam int F_Z = 0; // Zero
	localparam int F_M = 1; // Minus
	localparam int F_V = 2; // Overflow, sticky
	localparam int F_C = 3; // Carry
	localparam int F_L = 4; // Less
	localparam int F_E = 5; // Equal
	localparam int F_G = 6; // Greater
	localparam int F_Y = 7; // Extension Y
	localparam int F_X = 8; // Extension X, user writable

endpackage

`default_nettype wire

// ==== pr.f ====
common/pr_pkg.sv
verilog/regs.sv
r0/r0_ctl.sv
r0/r0.sv
verilog/nb_q_bs.sv
verilog/pr.sv
sim/pr_tb.sv

// ==== r0/r0.sv ====
/*
	R0 register with ZMVCLEGYX flags and user bits 9..15
	ALU flag updates on strob1, W loads take priority
*/

`default_nettype none

module r0 (
	input  wire            clk_sys,
	input  wire            rst,
	input  wire            zer,     // Clear R0
	input  pr_pkg::word_t  w,
	input  wire            ld_all,  // Load bits 0..15
	input  wire            ld_low,  // Load bits 8..15
	input  wire            strob1,
	input  wire            ust_z,
	input  wire            ust_mc,
	input  wire            ust_v,
	input  wire            ust_leg,
	input  wire            ust_y,
	input  wire            ust_x,
	input  wire            zs,
	input  wire            s0,
	input  wire            carry,
	input  wire            ovf,
	input  wire            cmp_l,
	input  wire            cmp_g,
	input  wire            exy,
	input  wire            exx,
	output pr_pkg::flags_t flags,
	output logic [9:15]    ubits    // User part of R0
);

	import pr_pkg::*;

	always_ff @(posedge clk_sys) begin
		if (rst || zer) begin
			flags <= '0;
			ubits <= '0;
		end else begin
			if (strob1) begin
				if (ust_z) flags[F_Z] <= zs;
				if (ust_mc) begin
					flags[F_M] <= s0;    // Sign of result
					flags[F_C] <= carry;
				end
				if (ust_v && ovf) flags[F_V] <= 1'b1; // Sticky until written
				if (ust_leg) begin
					flags[F_L] <= cmp_l;
					flags[F_E] <= zs;
					flags[F_G] <= cmp_g;
				end
				if (ust_y) flags[F_Y] <= exy;
				if (ust_x) flags[F_X] <= exx;
			end
			// W loads come last so they override ALU updates per bit
			if (ld_all) begin
				flags[F_Z:F_Y] <= w[0:7];
			end
			if (ld_all || ld_low) begin
				flags[F_X] <= w[8];
				ubits      <= w[9:15];
			end
		end
	end

	// Full and partial loads come from mutually exclusive decode terms
	a_ld_excl: assert property (
		@(posedge clk_sys) disable iff (rst)
		!(ld_all && ld_low)
	) else $error("R0 full and partial load together");

endmodule

`default_nettype wire

// ==== r0/r0_ctl.sv ====
/*
	R0 and user register control decode
	Load enables, read selects and L/G comparison results
*/

`default_nettype none

module r0_ctl (
	input  pr_pkg::reg_addr_t addr,
	input  wire               w_r,        // Register write cycle
	input  wire               reg_strobe, // strobe_a or strobe_b
	input  wire               strobe_a,
	input  wire               lpc,        // LPC instruction
	input  wire               wa,         // State WA
	input  wire               q,          // User mode
	input  wire               blr,        // Block register reads
	input  wire               aryt,       // Arithmetic compare
	input  wire               zs,
	input  wire               carry,
	input  wire               s_1,
	output logic              ld_all,     // Full R0 load
	output logic              ld_low,     // X and bits 9..15 only
	output logic              rd_r0,      // R0 onto L
	output logic              user_we,
	output logic              user_re,
	output logic              cmp_l,
	output logic              cmp_g
);

	logic is_r0;  // Address hits R0
	logic wr_reg; // Strobed register write
	logic wr_r0;
	logic lpc_ld; // LPC full load
	logic rd_ok;  // Reads allowed

	assign is_r0  = (addr == '0);
	assign wr_reg = w_r & reg_strobe;
	assign wr_r0  = wr_reg & is_r0;
	assign lpc_ld = lpc & wa & strobe_a;

	// System mode loads everything, user mode keeps the CPU flags
	assign ld_all = lpc_ld | (wr_r0 & ~q);
	assign ld_low = wr_r0 & q & ~lpc_ld; // LPC overrides mode rule

	assign user_we = wr_reg & ~is_r0;

	// No reads during writes or while registers are blocked
	assign rd_ok   = ~blr & ~w_r;
	assign rd_r0   = rd_ok & is_r0;
	assign user_re = rd_ok & ~is_r0;

	// Logical compare uses carry, arithmetic uses sign
	assign cmp_l = aryt ? s_1 : carry;
	assign cmp_g = aryt ? ~(zs | s_1) : ~(zs | carry);

endmodule

`default_nettype wire

// ==== sim/pr_tb.sv ====
/*
	Random-stimulus testbench for the P-R register unit
	Behavioral model, LFSR stimulus, value check and cycle timeout
*/

`default_nettype none

module pr_tb;

	import pr_pkg::*;

	localparam bit          CPU_NUMBER = 1'b0;
	localparam int          N_CYCLES   = 2000;               // Random cycles
	localparam int          TIMEOUT    = N_CYCLES + N_CYCLES / 4; // Margin for reset
	localparam logic [31:0] SEED       = 32'h91e9_0dc2;

	logic clk_sys, rst, blr, lpc, wa, as2, w_r, strob1, strob2;
	logic bar_nb, w_rba, w_rbb, w_rbc, rpn, bp_nb, pn_nb, q_nb, w_bar, zer_fp, clm;
	logic aryt, zs, carry, s_1, s0, ovf, exy, exx, kia, kib;
	logic ust_z, ust_mc, ust_v, ust_leg, ust_y, ust_x;
	word_t     w, rz, zp;
	reg_addr_t addr;
	rs_t       rs;
	word_t     l, ki;
	flags_t    r0;
	nb_t       dnb;
	logic      q, zgpn, dpn, dqb, zer;

	word_t       m_reg [1:7]; // Model R1..R7
	flags_t      m_flags;
	logic [9:15] m_ubits;
	nb_t         m_nb;
	logic        m_q, m_bs;
	word_t       m_rb;
	logic [31:0] lfsr;
	int          cycles;

	pr #(.CPU_NUMBER(CPU_NUMBER)) dut (
		.clk_sys(clk_sys), .rst(rst), .blr(blr), .lpc(lpc), .wa(wa), .as2(as2),
		.w_r(w_r), .strob1(strob1), .strob2(strob2), .w(w), .addr(addr),
		.bar_nb(bar_nb), .w_rba(w_rba), .w_rbb(w_rbb), .w_rbc(w_rbc), .rpn(rpn),
		.bp_nb(bp_nb), .pn_nb(pn_nb), .q_nb(q_nb), .w_bar(w_bar), .zer_fp(zer_fp),
		.clm(clm), .aryt(aryt), .zs(zs), .carry(carry), .s_1(s_1), .s0(s0), .ovf(ovf),
		.ust_z(ust_z), .ust_mc(ust_mc), .ust_v(ust_v), .ust_leg(ust_leg),
		.ust_y(ust_y), .ust_x(ust_x), .exy(exy), .exx(exx), .kia(kia), .kib(kib),
		.rz(rz), .zp(zp), .rs(rs), .l(l), .ki(ki), .r0(r0), .dnb(dnb), .q(q),
		.zgpn(zgpn), .dpn(dpn), .dqb(dqb), .zer(zer)
	);

	always #4 clk_sys = ~clk_sys; // Period 8

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT);
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	end

	// Right-shift Galois form, taps x^32+x^22+x^2+x+1
	function automatic logic [31:0] galois_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			v    = {v[30:0], lfsr[0]}; // One step per bit
			lfsr = galois_step(lfsr);
		end
		return v;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] time %0t: %s is %0h, expected %0h", $time, name, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	endtask

	task automatic drive_inputs();
		blr = (take_bits(2) == 0); // Blocked reads a quarter of the time
		lpc = (take_bits(2) == 0);
		wa = take_bits(1); as2 = take_bits(1); w_r = take_bits(1);
		strob1 = take_bits(1); strob2 = take_bits(1);
		w = take_bits(16); addr = take_bits(3);
		bar_nb = take_bits(1); q_nb = take_bits(1); bp_nb = take_bits(1);
		pn_nb = take_bits(1); rpn = take_bits(1);
		w_rba = take_bits(1); w_rbb = take_bits(1); w_rbc = take_bits(1);
		w_bar = (take_bits(2) == 0);
		clm = (take_bits(6) == 0);    // Rare clears keep state alive
		zer_fp = (take_bits(6) == 0);
		aryt = take_bits(1); zs = take_bits(1); carry = take_bits(1);
		s_1 = take_bits(1); s0 = take_bits(1); ovf = take_bits(1);
		ust_z = take_bits(1); ust_mc = take_bits(1); ust_v = take_bits(1);
		ust_leg = take_bits(1); ust_y = take_bits(1); ust_x = take_bits(1);
		exy = take_bits(1); exx = take_bits(1);
		kia = take_bits(1); kib = take_bits(1);
		rz = take_bits(16); zp = take_bits(16); rs = take_bits(10);
	endtask

	// Combinational outputs from model state and current inputs
	task automatic check_outputs();
		word_t e_l, e_ki;
		e_l = '0;
		if (!blr && !w_r) begin
			if (addr == 0) e_l = {m_flags, m_ubits};
			else e_l = m_reg[addr];
		end
		if (blr) e_l = {8'h00, m_flags[F_Z:F_Y]}; // Flag view Z..Y in bits 8..15
		case ({kia, kib})
			2'b00:   e_ki = rz;
			2'b01:   e_ki = {rs, m_bs, m_q, m_nb};
			2'b10:   e_ki = m_rb;
			default: e_ki = zp;
		endcase
		check_value("l", l, e_l);
		check_value("ki", ki, e_ki);
		check_value("r0", r0, m_flags);
		check_value("q", q, m_q);
		check_value("dnb", dnb, bar_nb ? m_nb : 4'h0);
		check_value("dqb", dqb, q_nb & m_q);
		check_value("dpn", dpn, (bp_nb & (m_bs ^ CPU_NUMBER)) | (pn_nb & CPU_NUMBER));
		check_value("zgpn", zgpn, rpn ^ CPU_NUMBER);
		check_value("zer", zer, clm | zer_fp);
	endtask

	// State update at the rising edge, R0 before Q since R0 rule uses old Q
	task automatic update_model();
		logic sa, sb, wr, wr_r0, lpc_ld, full, part, ld_bar;
		sa     = strob1 & ~as2;
		sb     = strob2 & as2;
		wr     = w_r & (sa | sb);
		wr_r0  = wr & (addr == 0);
		lpc_ld = lpc & wa & sa;
		full   = lpc_ld | (wr_r0 & ~m_q);
		part   = wr_r0 & m_q & ~lpc_ld;
		ld_bar = w_bar & strob1;
		if (rst) begin
			for (int i = 1; i <= 7; i++) m_reg[i] = '0;
			m_flags = '0; m_ubits = '0; m_nb = '0; m_q = 0; m_bs = 0; m_rb = '0;
		end else begin
			if (wr && addr != 0) m_reg[addr] = w;
			if (clm || zer_fp) begin
				m_flags = '0;
				m_ubits = '0;
			end else begin
				if (strob1) begin
					if (ust_z) m_flags[F_Z] = zs;
					if (ust_mc) begin
						m_flags[F_M] = s0;
						m_flags[F_C] = carry;
					end
					if (ust_v && ovf) m_flags[F_V] = 1'b1; // Sticky
					if (ust_leg) begin
						m_flags[F_E] = zs;
						m_flags[F_L] = aryt ? s_1 : carry;
						m_flags[F_G] = aryt ? (!zs && !s_1) : (!zs && !carry);
					end
					if (ust_y) m_flags[F_Y] = exy;
					if (ust_x) m_flags[F_X] = exx;
				end
				if (full) m_flags[F_Z:F_Y] = w[0:7]; // W load wins
				if (full || part) begin
					m_flags[F_X] = w[8];
					m_ubits      = w[9:15];
				end
			end
			if (clm) begin
				m_nb = '0;
				m_bs = 0;
			end else if (ld_bar) begin
				m_nb = w[12:15];
				m_bs = w[11];
			end
			if (clm || zer_fp) m_q = 0;
			else if (ld_bar) m_q = w[10];
			if (w_rbc) m_rb[0:3]   = w[12:15];
			if (w_rbb) m_rb[4:9]   = w[10:15];
			if (w_rba) m_rb[10:15] = w[10:15];
		end
	endtask

	initial begin
		clk_sys = 0; rst = 1; cycles = 0; lfsr = SEED;
		blr = 0; lpc = 0; wa = 0; as2 = 0; w_r = 0; strob1 = 0; strob2 = 0;
		w = '0; addr = '0; bar_nb = 0; w_rba = 0; w_rbb = 0; w_rbc = 0; rpn = 0;
		bp_nb = 0; pn_nb = 0; q_nb = 0; w_bar = 0; zer_fp = 0; clm = 0;
		aryt = 0; zs = 0; carry = 0; s_1 = 0; s0 = 0; ovf = 0;
		ust_z = 0; ust_mc = 0; ust_v = 0; ust_leg = 0; ust_y = 0; ust_x = 0;
		exy = 0; exx = 0; kia = 0; kib = 0; rz = '0; zp = '0; rs = '0;
		update_model(); // Model starts from reset state
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		rst = 0;
		#2 check_outputs(); // Idle buses after reset
		@(posedge clk_sys);
		update_model();
		for (int n = 0; n < N_CYCLES; n++) begin
			@(negedge clk_sys);
			drive_inputs();
			#2 check_outputs();
			@(posedge clk_sys);
			update_model();
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/nb_q_bs.sv ====
/*
	NB, Q and BS system registers
	System bus drivers and CPU number logic
*/

`default_nettype none

module nb_q_bs #(
	parameter bit CPU_NUMBER = 1'b0 // Jumper selected CPU number
) (
	input  wire           clk_sys,
	input  wire           rst,
	input  wire           w_bar,   // W -> NB, Q, BS
	input  wire           strob1,
	input  wire           clm,     // Master clear
	input  wire           zer,     // Clears Q
	input  pr_pkg::word_t w,
	input  wire           bar_nb,  // Drive NB on system bus
	input  wire           q_nb,    // Drive Q on system bus
	input  wire           bp_nb,
	input  wire           pn_nb,
	input  wire           rpn,
	output pr_pkg::nb_t   nb,
	output logic          q,       // System flag
	output logic          bs,
	output pr_pkg::nb_t   dnb,
	output logic          dqb,
	output logic          dpn,
	output logic          zgpn
);

	logic ld_bar; // Strobed system register load

	assign ld_bar = w_bar & strob1;

	always_ff @(posedge clk_sys) begin
		if (rst || clm) begin
			nb <= '0;
			bs <= 1'b0;
		end else if (ld_bar) begin
			nb <= w[12:15];
			bs <= w[11];
		end
	end

	// zer already covers clm
	always_ff @(posedge clk_sys) begin
		if (rst || zer) q <= 1'b0;
		else if (ld_bar) q <= w[10];
	end

	assign dnb  = bar_nb ? nb : '0;
	assign dqb  = q_nb & q;
	assign dpn  = (bp_nb & (bs ^ CPU_NUMBER)) | (pn_nb & CPU_NUMBER);
	assign zgpn = rpn ^ CPU_NUMBER; // Request for this CPU

endmodule

`default_nettype wire

// ==== verilog/pr.sv ====
/*
	P-R register unit top level
	Strobe selection, RB register, L bus composition and KI multiplexer
*/

`default_nettype none

module pr #(
	parameter bit CPU_NUMBER = 1'b0
) (
	input  wire               clk_sys,
	input  wire               rst,
	input  wire               blr,     // Block register reads
	input  wire               lpc,
	input  wire               wa,
	input  wire               as2,     // Strobe select
	input  wire               w_r,
	input  wire               strob1,
	input  wire               strob2,
	input  pr_pkg::word_t     w,       // W bus
	input  pr_pkg::reg_addr_t addr,
	input  wire               bar_nb,
	input  wire               w_rba,   // RB[10:15] load
	input  wire               w_rbb,   // RB[4:9] load
	input  wire               w_rbc,   // RB[0:3] load
	input  wire               rpn,
	input  wire               bp_nb,
	input  wire               pn_nb,
	input  wire               q_nb,
	input  wire               w_bar,
	input  wire               zer_fp,
	input  wire               clm,
	input  wire               aryt,
	input  wire               zs,
	input  wire               carry,
	input  wire               s_1,
	input  wire               s0,
	input  wire               ovf,
	input  wire               ust_z,
	input  wire               ust_mc,
	input  wire               ust_v,
	input  wire               ust_leg,
	input  wire               ust_y,
	input  wire               ust_x,
	input  wire               exy,
	input  wire               exx,
	input  wire               kia,
	input  wire               kib,
	input  pr_pkg::word_t     rz,
	input  pr_pkg::word_t     zp,
	input  pr_pkg::rs_t       rs,
	output pr_pkg::word_t     l,       // L bus
	output pr_pkg::word_t     ki,      // KI diagnostic bus
	output pr_pkg::flags_t    r0,
	output pr_pkg::nb_t       dnb,
	output logic              q,
	output logic              zgpn,
	output logic              dpn,
	output logic              dqb,
	output logic              zer
);

	import pr_pkg::*;

	logic        strobe_a;
	logic        strobe_b;
	logic        reg_strobe;
	logic        ld_all;
	logic        ld_low;
	logic        rd_r0;
	logic        user_we;
	logic        user_re;
	logic        cmp_l;
	logic        cmp_g;
	logic        bs;
	logic [9:15] ubits;
	nb_t         nb;
	word_t       user_rdata;
	word_t       rb;
	word_t       l_r0;    // R0 at native positions
	word_t       l_flags; // Flags shifted right by 8

	assign strobe_a   = strob1 & ~as2;
	assign strobe_b   = strob2 & as2;
	assign reg_strobe = strobe_a | strobe_b;
	assign zer        = clm | zer_fp;

	regs u_regs (
		.clk_sys(clk_sys), .rst(rst),
		.we(user_we), .re(user_re),
		.addr(addr), .w(w),
		.rdata(user_rdata)
	);

	r0_ctl u_r0_ctl (
		.addr(addr), .w_r(w_r),
		.reg_strobe(reg_strobe), .strobe_a(strobe_a),
		.lpc(lpc), .wa(wa), .q(q), .blr(blr),
		.aryt(aryt), .zs(zs), .carry(carry), .s_1(s_1),
		.ld_all(ld_all), .ld_low(ld_low), .rd_r0(rd_r0),
		.user_we(user_we), .user_re(user_re),
		.cmp_l(cmp_l), .cmp_g(cmp_g)
	);

	r0 u_r0 (
		.clk_sys(clk_sys), .rst(rst), .zer(zer), .w(w),
		.ld_all(ld_all), .ld_low(ld_low), .strob1(strob1),
		.ust_z(ust_z), .ust_mc(ust_mc), .ust_v(ust_v),
		.ust_leg(ust_leg), .ust_y(ust_y), .ust_x(ust_x),
		.zs(zs), .s0(s0), .carry(carry), .ovf(ovf),
		.cmp_l(cmp_l), .cmp_g(cmp_g), .exy(exy), .exx(exx),
		.flags(r0), .ubits(ubits)
	);

	nb_q_bs #(
		.CPU_NUMBER(CPU_NUMBER)
	) u_nb_q_bs (
		.clk_sys(clk_sys), .rst(rst),
		.w_bar(w_bar), .strob1(strob1), .clm(clm), .zer(zer), .w(w),
		.bar_nb(bar_nb), .q_nb(q_nb), .bp_nb(bp_nb), .pn_nb(pn_nb), .rpn(rpn),
		.nb(nb), .q(q), .bs(bs),
		.dnb(dnb), .dqb(dqb), .dpn(dpn), .zgpn(zgpn)
	);

	// RB parts all take the low bits of w[10:15]
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			rb <= '0;
		end else begin
			if (w_rbc) rb[0:3]   <= w[12:15];
			if (w_rbb) rb[4:9]   <= w[10:15];
			if (w_rba) rb[10:15] <= w[10:15];
		end
	end

	assign l_r0    = rd_r0 ? {r0, ubits} : '0;
	assign l_flags = blr ? {8'h00, r0[F_Z:F_Y]} : '0; // Z..Y into bits 8..15

	// Idle L sources drive zero so a plain OR merges them
	assign l = user_rdata | l_r0 | l_flags;

	always_comb begin
		case ({kia, kib})
			2'b00:   ki = rz;
			2'b01:   ki = {rs, bs, q, nb}; // Status view
			2'b10:   ki = rb;
			default: ki = zp;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/regs.sv ====
/*
	User register file R1..R7
	Strobed write, addressed combinational read gated by re
*/

`default_nettype none

module regs (
	input  wire               clk_sys,
	input  wire               rst,
	input  wire               we,       // Write strobe, addr 1..7 only
	input  wire               re,       // Read enable onto L
	input  pr_pkg::reg_addr_t addr,
	input  pr_pkg::word_t     w,
	output pr_pkg::word_t     rdata
);

	import pr_pkg::*;

	word_t mem [1:7]; // R1..R7

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			for (int i = 1; i <= 7; i++) begin
				mem[i] <= '0;
			end
		end else if (we && (addr != '0)) begin
			mem[addr] <= w; // Load at the strobe edge
		end
	end

	// Idle bus reads as zero so the L OR stays clean
	assign rdata = (re && (addr != '0)) ? mem[addr] : '0;

	// R0 writes must be steered to the R0 block by the control decode
	a_no_r0_write: assert property (
		@(posedge clk_sys) disable iff (rst)
		we |-> (addr != '0)
	) else $error("user register write with addr 0");

endmodule

`default_nettype wire
